//--- source/mmu_pkg.sv
// ----------------------------------------
// Shared widths, TLB geometry and encodings
// One page size only, 4 KiB pages
// Direct-mapped TLB, no associativity
// Command word is one install or one
// invalidate per transfer
// ----------------------------------------
package mmu_pkg;

  // Address and page geometry
  localparam int VADDR_BITS = 32;
  localparam int PADDR_BITS = 32;
  localparam int PG_BITS    = 12;
  localparam int VPN_BITS   = VADDR_BITS - PG_BITS;
  localparam int PPN_BITS   = PADDR_BITS - PG_BITS;

  // TLB index and tag split of the virtual page number
  localparam int TLB_ORDER = 4;
  localparam int TLB_DEPTH = 1 << TLB_ORDER;
  localparam int TAG_BITS  = VPN_BITS - TLB_ORDER;

  // Request fields
  localparam int PID_BITS = 4;
  localparam int LEN_BITS = 16;

  // Outstanding DMA requests per channel
  localparam int N_CREDITS = 4;
  localparam int CRED_BITS = $clog2(N_CREDITS + 1);

  // Command opcodes
  localparam logic CMD_INSTALL = 1'b1;
  localparam logic CMD_INVLDT  = 1'b0;

  // Channel FSM state codes
  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_LOCK   = 3'd1;
  localparam logic [2:0] ST_LOOKUP = 3'd2;
  localparam logic [2:0] ST_RESULT = 3'd3;
  localparam logic [2:0] ST_ISSUE  = 3'd4;
  localparam logic [2:0] ST_FAULT  = 3'd5;

  // Mutex state codes
  localparam logic [1:0] MTX_FREE = 2'd0;
  localparam logic [1:0] MTX_RD   = 2'd1;
  localparam logic [1:0] MTX_WR   = 2'd2;

  // ----------------------------------------
  // TLB command word, opcode bit leads
  // ----------------------------------------
  typedef union packed {
    struct packed {
      logic                op;
      logic [VPN_BITS-1:0] vpn;
      logic [PID_BITS-1:0] pid;
      logic [PPN_BITS-1:0] ppn;
    } install;
    struct packed {
      logic                op;
      logic [VPN_BITS-1:0] vpn;
      logic [PID_BITS-1:0] pid;
      // Zero on invalidate
      logic [PPN_BITS-1:0] pad;
    } invldt;
  } tlb_cmd_u;

endpackage

//--- source/tlb_lookup_if.sv
// ----------------------------------------
// Lookup port between a requester and TLB
// Valid is a single-cycle pulse
// Hit and paddr arrive one cycle later and
// hold until the next pulse
// ----------------------------------------
`timescale 1ns/1ps

interface tlb_lookup_if;

  // Requester side
  logic                          valid;
  logic [mmu_pkg::VADDR_BITS-1:0] vaddr;
  logic [mmu_pkg::PID_BITS-1:0]   pid;

  // TLB side
  logic                           hit;
  logic [mmu_pkg::PADDR_BITS-1:0] paddr;

  modport requester (output valid, vaddr, pid, input hit, paddr);
  modport tlb (input valid, vaddr, pid, output hit, paddr);

endinterface

//--- source/tlb_store.sv
// ----------------------------------------
// Direct-mapped translation table
// Command port always accepts, write lands
// at the clock edge
// A lookup in the same cycle as a command
// sees the old contents
// Result registered, held until next lookup
// ----------------------------------------
`timescale 1ns/1ps

module tlb_store (
  input  logic              aclk,
  input  logic              aresetn,
  input  logic              s_cmd_valid,
  input  mmu_pkg::tlb_cmd_u s_cmd,
  tlb_lookup_if.tlb         lkp
);

  // Entry storage
  logic [mmu_pkg::TLB_DEPTH-1:0] vld_q;
  logic [mmu_pkg::TAG_BITS-1:0]  tag_mem [mmu_pkg::TLB_DEPTH];
  logic [mmu_pkg::PID_BITS-1:0]  pid_mem [mmu_pkg::TLB_DEPTH];
  logic [mmu_pkg::PPN_BITS-1:0]  ppn_mem [mmu_pkg::TLB_DEPTH];

  // Command address split
  logic [mmu_pkg::TLB_ORDER-1:0] cmd_idx;
  logic [mmu_pkg::TAG_BITS-1:0]  cmd_tag;
  logic                          cmd_match;

  // Lookup address split
  logic [mmu_pkg::TLB_ORDER-1:0] lkp_idx;
  logic [mmu_pkg::TAG_BITS-1:0]  lkp_tag;

  // Both views share vpn and pid positions
  assign cmd_idx = s_cmd.install.vpn[mmu_pkg::TLB_ORDER-1:0];
  assign cmd_tag = s_cmd.install.vpn[mmu_pkg::VPN_BITS-1 -: mmu_pkg::TAG_BITS];

  // Invalidate only hits its own page and process
  assign cmd_match = (tag_mem[cmd_idx] == cmd_tag) &&
                     (pid_mem[cmd_idx] == s_cmd.invldt.pid);

  assign lkp_idx = lkp.vaddr[mmu_pkg::PG_BITS +: mmu_pkg::TLB_ORDER];
  assign lkp_tag = lkp.vaddr[mmu_pkg::VADDR_BITS-1 -: mmu_pkg::TAG_BITS];

  // ----------------------------------------
  // Command write port
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      vld_q <= '0;
    end else if (s_cmd_valid) begin
      case (s_cmd.install.op)
        mmu_pkg::CMD_INSTALL: begin
          vld_q[cmd_idx] <= 1'b1;
        end
        mmu_pkg::CMD_INVLDT: begin
          if (cmd_match) begin
            vld_q[cmd_idx] <= 1'b0;
          end
        end
        default: begin
          vld_q <= vld_q;
        end
      endcase
    end
  end

  // Entry payload, valid bit guards it
  always_ff @(posedge aclk) begin
    if (s_cmd_valid && (s_cmd.install.op == mmu_pkg::CMD_INSTALL)) begin
      tag_mem[cmd_idx] <= cmd_tag;
      pid_mem[cmd_idx] <= s_cmd.install.pid;
      ppn_mem[cmd_idx] <= s_cmd.install.ppn;
    end
  end

  // ----------------------------------------
  // Lookup port
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lkp.hit <= 1'b0;
    end else if (lkp.valid) begin
      lkp.hit <= vld_q[lkp_idx] &&
                 (tag_mem[lkp_idx] == lkp_tag) &&
                 (pid_mem[lkp_idx] == lkp.pid);
    end
  end

  // Physical page followed by page offset
  always_ff @(posedge aclk) begin
    if (lkp.valid) begin
      lkp.paddr <= {ppn_mem[lkp_idx], lkp.vaddr[mmu_pkg::PG_BITS-1:0]};
    end
  end

endmodule

//--- source/tlb_mutex.sv
// ----------------------------------------
// Two-channel lock on the TLB lookup port
// Grant follows a request by one cycle
// Read wins when both ask while free
// Owner must drop lock with its unlock pulse
// ----------------------------------------
`timescale 1ns/1ps

module tlb_mutex (
  input  logic            aclk,
  input  logic            aresetn,
  input  logic            rd_lock,
  input  logic            rd_unlock,
  input  logic            wr_lock,
  input  logic            wr_unlock,
  output logic            rd_grant,
  output logic            wr_grant,
  tlb_lookup_if.tlb       rd_lkp,
  tlb_lookup_if.tlb       wr_lkp,
  tlb_lookup_if.requester tlb_lkp
);

  logic [1:0] mtx_q;

  // Lock state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      mtx_q <= mmu_pkg::MTX_FREE;
    end else begin
      case (mtx_q)
        mmu_pkg::MTX_FREE: begin
          if (rd_lock) begin
            mtx_q <= mmu_pkg::MTX_RD;
          end else if (wr_lock) begin
            mtx_q <= mmu_pkg::MTX_WR;
          end
        end
        // Only the owner can release
        mmu_pkg::MTX_RD: if (rd_unlock) mtx_q <= mmu_pkg::MTX_FREE;
        mmu_pkg::MTX_WR: if (wr_unlock) mtx_q <= mmu_pkg::MTX_FREE;
        default: mtx_q <= mmu_pkg::MTX_FREE;
      endcase
    end
  end

  assign rd_grant = (mtx_q == mmu_pkg::MTX_RD);
  assign wr_grant = (mtx_q == mmu_pkg::MTX_WR);

  // Owner steers the request side, no pulse while free
  assign tlb_lkp.valid = (rd_grant && rd_lkp.valid) || (wr_grant && wr_lkp.valid);
  assign tlb_lkp.vaddr = wr_grant ? wr_lkp.vaddr : rd_lkp.vaddr;
  assign tlb_lkp.pid   = wr_grant ? wr_lkp.pid : rd_lkp.pid;

  // Result goes back to both, only the owner samples it
  assign rd_lkp.hit   = tlb_lkp.hit;
  assign rd_lkp.paddr = tlb_lkp.paddr;
  assign wr_lkp.hit   = tlb_lkp.hit;
  assign wr_lkp.paddr = tlb_lkp.paddr;

endmodule

//--- source/translate_fsm.sv
// ----------------------------------------
// Per-channel translation FSM
// One request in flight per channel
// Ready only while idle
// A miss holds a page fault until resume,
// then the lookup is retried
// No credit after a hit stalls the channel
// ----------------------------------------
`timescale 1ns/1ps

module translate_fsm (
  input  logic                           aclk,
  input  logic                           aresetn,
  input  logic                           req_valid,
  output logic                           req_ready,
  input  logic [mmu_pkg::VADDR_BITS-1:0] req_vaddr,
  input  logic [mmu_pkg::LEN_BITS-1:0]   req_len,
  input  logic [mmu_pkg::PID_BITS-1:0]   req_pid,
  output logic                           lock,
  output logic                           unlock,
  input  logic                           grant,
  tlb_lookup_if.requester                lkp,
  input  logic                           has_credit,
  output logic                           dma_valid,
  output logic [mmu_pkg::PADDR_BITS-1:0] dma_paddr,
  output logic [mmu_pkg::LEN_BITS-1:0]   dma_len,
  output logic [mmu_pkg::PID_BITS-1:0]   dma_pid,
  output logic                           pfault_valid,
  output logic [mmu_pkg::VADDR_BITS-1:0] pfault_vaddr,
  output logic [mmu_pkg::PID_BITS-1:0]   pfault_pid,
  input  logic                           pfault_resume
);

  logic [2:0] state_q;
  logic [2:0] state_d;

  // Request fields, held for the whole transaction
  logic [mmu_pkg::VADDR_BITS-1:0] vaddr_q;
  logic [mmu_pkg::LEN_BITS-1:0]   len_q;
  logic [mmu_pkg::PID_BITS-1:0]   pid_q;
  logic [mmu_pkg::PADDR_BITS-1:0] paddr_q;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      mmu_pkg::ST_IDLE:   if (req_valid) state_d = mmu_pkg::ST_LOCK;
      mmu_pkg::ST_LOCK:   if (grant) state_d = mmu_pkg::ST_LOOKUP;
      mmu_pkg::ST_LOOKUP: state_d = mmu_pkg::ST_RESULT;
      mmu_pkg::ST_RESULT: begin
        if (!lkp.hit) begin
          state_d = mmu_pkg::ST_FAULT;
        end else if (has_credit) begin
          state_d = mmu_pkg::ST_IDLE;
        end else begin
          state_d = mmu_pkg::ST_ISSUE;
        end
      end
      // Wait for a returned credit
      mmu_pkg::ST_ISSUE:  if (has_credit) state_d = mmu_pkg::ST_IDLE;
      // Software installed the page, retry
      mmu_pkg::ST_FAULT:  if (pfault_resume) state_d = mmu_pkg::ST_LOCK;
      default:            state_d = mmu_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= mmu_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture on accept
  always_ff @(posedge aclk) begin
    if (req_valid && req_ready) begin
      vaddr_q <= req_vaddr;
      len_q   <= req_len;
      pid_q   <= req_pid;
    end
  end

  // Keep the translation past the unlock, the other channel may reuse the TLB
  always_ff @(posedge aclk) begin
    if (state_q == mmu_pkg::ST_RESULT) begin
      paddr_q <= lkp.paddr;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign req_ready = (state_q == mmu_pkg::ST_IDLE);
  assign lock      = (state_q == mmu_pkg::ST_LOCK);
  assign unlock    = (state_q == mmu_pkg::ST_RESULT);

  assign lkp.valid = (state_q == mmu_pkg::ST_LOOKUP);
  assign lkp.vaddr = vaddr_q;
  assign lkp.pid   = pid_q;

  // Also the issue strobe toward the credit gate
  assign dma_valid = has_credit &&
                     (((state_q == mmu_pkg::ST_RESULT) && lkp.hit) ||
                      (state_q == mmu_pkg::ST_ISSUE));
  assign dma_paddr = (state_q == mmu_pkg::ST_RESULT) ? lkp.paddr : paddr_q;
  assign dma_len   = len_q;
  assign dma_pid   = pid_q;

  // Raised in the result cycle, held in fault
  assign pfault_valid = ((state_q == mmu_pkg::ST_RESULT) && !lkp.hit) ||
                        (state_q == mmu_pkg::ST_FAULT);
  assign pfault_vaddr = vaddr_q;
  assign pfault_pid   = pid_q;

endmodule

//--- source/dma_credit_gate.sv
// ----------------------------------------
// Credit counter toward the DMA engine
// Starts full after reset
// Done pulses beyond N_CREDITS are dropped
// Issue is only legal with a credit held
// ----------------------------------------
`timescale 1ns/1ps

module dma_credit_gate (
  input  logic aclk,
  input  logic aresetn,
  input  logic issue,
  input  logic xfer_done,
  output logic has_credit
);

  logic [mmu_pkg::CRED_BITS-1:0] cred_q;
  logic                          cred_full;

  assign cred_full  = (cred_q == mmu_pkg::CRED_BITS'(mmu_pkg::N_CREDITS));
  assign has_credit = (cred_q != '0);

  // ----------------------------------------
  // Up/down count
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cred_q <= mmu_pkg::CRED_BITS'(mmu_pkg::N_CREDITS);
    end else begin
      case ({issue, xfer_done})
        // Spend one
        2'b10: begin
          if (has_credit) begin
            cred_q <= cred_q - 1'b1;
          end
        end
        // Return one, saturate at full
        2'b01: begin
          if (!cred_full) begin
            cred_q <= cred_q + 1'b1;
          end
        end
        // Both or neither cancel out
        default: begin
          cred_q <= cred_q;
        end
      endcase
    end
  end

endmodule

//--- source/mmu_region.sv
// ----------------------------------------
// MMU for one user region
// Separate read and write channels share
// one TLB through a two-state mutex
// Each channel has its own DMA credits
// ----------------------------------------
`timescale 1ns/1ps

module mmu_region (
  input  logic                           aclk,
  input  logic                           aresetn,
  // TLB command port
  input  logic                           s_tlb_cmd_valid,
  input  mmu_pkg::tlb_cmd_u              s_tlb_cmd,
  // Read request
  input  logic                           s_rd_req_valid,
  output logic                           s_rd_req_ready,
  input  logic [mmu_pkg::VADDR_BITS-1:0] s_rd_req_vaddr,
  input  logic [mmu_pkg::LEN_BITS-1:0]   s_rd_req_len,
  input  logic [mmu_pkg::PID_BITS-1:0]   s_rd_req_pid,
  // Write request
  input  logic                           s_wr_req_valid,
  output logic                           s_wr_req_ready,
  input  logic [mmu_pkg::VADDR_BITS-1:0] s_wr_req_vaddr,
  input  logic [mmu_pkg::LEN_BITS-1:0]   s_wr_req_len,
  input  logic [mmu_pkg::PID_BITS-1:0]   s_wr_req_pid,
  // Read DMA
  output logic                           m_rd_dma_valid,
  output logic [mmu_pkg::PADDR_BITS-1:0] m_rd_dma_paddr,
  output logic [mmu_pkg::LEN_BITS-1:0]   m_rd_dma_len,
  output logic [mmu_pkg::PID_BITS-1:0]   m_rd_dma_pid,
  input  logic                           rd_xfer_done,
  // Write DMA
  output logic                           m_wr_dma_valid,
  output logic [mmu_pkg::PADDR_BITS-1:0] m_wr_dma_paddr,
  output logic [mmu_pkg::LEN_BITS-1:0]   m_wr_dma_len,
  output logic [mmu_pkg::PID_BITS-1:0]   m_wr_dma_pid,
  input  logic                           wr_xfer_done,
  // Page faults
  output logic                           m_rd_pfault_valid,
  output logic [mmu_pkg::VADDR_BITS-1:0] m_rd_pfault_vaddr,
  output logic [mmu_pkg::PID_BITS-1:0]   m_rd_pfault_pid,
  input  logic                           rd_pfault_resume,
  output logic                           m_wr_pfault_valid,
  output logic [mmu_pkg::VADDR_BITS-1:0] m_wr_pfault_vaddr,
  output logic [mmu_pkg::PID_BITS-1:0]   m_wr_pfault_pid,
  input  logic                           wr_pfault_resume
);

  // Lock handshake
  logic rd_lock, rd_unlock, rd_grant;
  logic wr_lock, wr_unlock, wr_grant;

  // Credit status
  logic rd_has_credit;
  logic wr_has_credit;

  // Lookup ports, per channel and shared
  tlb_lookup_if rd_lkp ();
  tlb_lookup_if wr_lkp ();
  tlb_lookup_if tlb_lkp ();

  // ----------------------------------------
  // Shared TLB and its lock
  // ----------------------------------------
  tlb_store tlb_i (
    .aclk(aclk), .aresetn(aresetn),
    .s_cmd_valid(s_tlb_cmd_valid), .s_cmd(s_tlb_cmd), .lkp(tlb_lkp)
  );

  tlb_mutex mutex_i (
    .aclk(aclk), .aresetn(aresetn),
    .rd_lock(rd_lock), .rd_unlock(rd_unlock),
    .wr_lock(wr_lock), .wr_unlock(wr_unlock),
    .rd_grant(rd_grant), .wr_grant(wr_grant),
    .rd_lkp(rd_lkp), .wr_lkp(wr_lkp), .tlb_lkp(tlb_lkp)
  );

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  translate_fsm rd_fsm_i (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(s_rd_req_valid), .req_ready(s_rd_req_ready),
    .req_vaddr(s_rd_req_vaddr), .req_len(s_rd_req_len), .req_pid(s_rd_req_pid),
    .lock(rd_lock), .unlock(rd_unlock), .grant(rd_grant), .lkp(rd_lkp),
    .has_credit(rd_has_credit),
    .dma_valid(m_rd_dma_valid), .dma_paddr(m_rd_dma_paddr),
    .dma_len(m_rd_dma_len), .dma_pid(m_rd_dma_pid),
    .pfault_valid(m_rd_pfault_valid), .pfault_vaddr(m_rd_pfault_vaddr),
    .pfault_pid(m_rd_pfault_pid), .pfault_resume(rd_pfault_resume)
  );

  dma_credit_gate rd_cred_i (
    .aclk(aclk), .aresetn(aresetn),
    .issue(m_rd_dma_valid), .xfer_done(rd_xfer_done), .has_credit(rd_has_credit)
  );

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  translate_fsm wr_fsm_i (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(s_wr_req_valid), .req_ready(s_wr_req_ready),
    .req_vaddr(s_wr_req_vaddr), .req_len(s_wr_req_len), .req_pid(s_wr_req_pid),
    .lock(wr_lock), .unlock(wr_unlock), .grant(wr_grant), .lkp(wr_lkp),
    .has_credit(wr_has_credit),
    .dma_valid(m_wr_dma_valid), .dma_paddr(m_wr_dma_paddr),
    .dma_len(m_wr_dma_len), .dma_pid(m_wr_dma_pid),
    .pfault_valid(m_wr_pfault_valid), .pfault_vaddr(m_wr_pfault_vaddr),
    .pfault_pid(m_wr_pfault_pid), .pfault_resume(wr_pfault_resume)
  );

  dma_credit_gate wr_cred_i (
    .aclk(aclk), .aresetn(aresetn),
    .issue(m_wr_dma_valid), .xfer_done(wr_xfer_done), .has_credit(wr_has_credit)
  );

endmodule

//--- dv/mmu_region_properties.sv
// ----------------------------------------
// Protocol assertions bound to mmu_region
// Sampled on aclk, off during reset
// ----------------------------------------
`timescale 1ns/1ps

module mmu_region_properties (
  input logic aclk,
  input logic aresetn,
  input logic rd_grant,
  input logic wr_grant,
  input logic m_rd_dma_valid,
  input logic m_wr_dma_valid,
  input logic m_rd_pfault_valid,
  input logic m_wr_pfault_valid,
  input logic rd_pfault_resume,
  input logic wr_pfault_resume,
  input logic s_rd_req_ready,
  input logic s_wr_req_ready
);

  // One owner of the TLB at a time
  a_one_owner: assert property (@(posedge aclk) disable iff (!aresetn)
    !(rd_grant && wr_grant)) else $error("Both channels hold the TLB lock");

  // DMA valid is a single-cycle pulse
  a_rd_dma_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    m_rd_dma_valid |=> !m_rd_dma_valid) else $error("Read DMA valid held");
  a_wr_dma_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    m_wr_dma_valid |=> !m_wr_dma_valid) else $error("Write DMA valid held");

  // Fault is a level until resume
  a_rd_fault_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_rd_pfault_valid && !rd_pfault_resume |=> m_rd_pfault_valid)
    else $error("Read page fault dropped without resume");
  a_wr_fault_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_wr_pfault_valid && !wr_pfault_resume |=> m_wr_pfault_valid)
    else $error("Write page fault dropped without resume");

  // No new request while faulted
  a_rd_fault_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    m_rd_pfault_valid |-> !s_rd_req_ready) else $error("Read ready during fault");
  a_wr_fault_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    m_wr_pfault_valid |-> !s_wr_req_ready) else $error("Write ready during fault");

endmodule

bind mmu_region mmu_region_properties props_i (
  .aclk(aclk), .aresetn(aresetn),
  .rd_grant(rd_grant), .wr_grant(wr_grant),
  .m_rd_dma_valid(m_rd_dma_valid), .m_wr_dma_valid(m_wr_dma_valid),
  .m_rd_pfault_valid(m_rd_pfault_valid), .m_wr_pfault_valid(m_wr_pfault_valid),
  .rd_pfault_resume(rd_pfault_resume), .wr_pfault_resume(wr_pfault_resume),
  .s_rd_req_ready(s_rd_req_ready), .s_wr_req_ready(s_wr_req_ready)
);

//--- dv/mmu_region_tb.sv
// ----------------------------------------
// Directed testbench for mmu_region
// Reference TLB follows install, invalidate
// and lookup rules of the design
// Stops at the first error
// Faults are served by an install + resume
// ----------------------------------------
`timescale 1ns/1ps

module mmu_region_tb;

  localparam int MAX_CYCLES = 4000;
  localparam int WAIT_LIMIT = 64;
  localparam int VA = mmu_pkg::VADDR_BITS;
  localparam int PA = mmu_pkg::PADDR_BITS;
  localparam int PG = mmu_pkg::PG_BITS;

  logic aclk;
  logic aresetn;
  logic s_tlb_cmd_valid;
  mmu_pkg::tlb_cmd_u s_tlb_cmd;
  logic s_rd_req_valid, s_rd_req_ready, s_wr_req_valid, s_wr_req_ready;
  logic [VA-1:0] s_rd_req_vaddr, s_wr_req_vaddr;
  logic [mmu_pkg::LEN_BITS-1:0] s_rd_req_len, s_wr_req_len;
  logic [mmu_pkg::PID_BITS-1:0] s_rd_req_pid, s_wr_req_pid;
  logic m_rd_dma_valid, m_wr_dma_valid, rd_xfer_done, wr_xfer_done;
  logic [PA-1:0] m_rd_dma_paddr, m_wr_dma_paddr;
  logic [mmu_pkg::LEN_BITS-1:0] m_rd_dma_len, m_wr_dma_len;
  logic [mmu_pkg::PID_BITS-1:0] m_rd_dma_pid, m_wr_dma_pid;
  logic m_rd_pfault_valid, m_wr_pfault_valid, rd_pfault_resume, wr_pfault_resume;
  logic [VA-1:0] m_rd_pfault_vaddr, m_wr_pfault_vaddr;
  logic [mmu_pkg::PID_BITS-1:0] m_rd_pfault_pid, m_wr_pfault_pid;

  // Reference TLB
  logic                         ref_vld [mmu_pkg::TLB_DEPTH];
  logic [mmu_pkg::TAG_BITS-1:0] ref_tag [mmu_pkg::TLB_DEPTH];
  logic [mmu_pkg::PID_BITS-1:0] ref_pid [mmu_pkg::TLB_DEPTH];
  logic [mmu_pkg::PPN_BITS-1:0] ref_ppn [mmu_pkg::TLB_DEPTH];

  logic [15:0] lfsr_q = 16'd44503;
  int          cycle_cnt = 0;

  mmu_region dut_i (.*);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Watchdog
  always @(posedge aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "Watchdog expired");
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Stopped at first error");
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic bit ref_hit(input logic [VA-1:0] va, input logic [3:0] pid);
    logic [mmu_pkg::TLB_ORDER-1:0] idx;
    idx = va[PG +: mmu_pkg::TLB_ORDER];
    return ref_vld[idx] && (ref_tag[idx] == va[VA-1 -: mmu_pkg::TAG_BITS]) &&
           (ref_pid[idx] == pid);
  endfunction

  // Physical page then page offset
  function automatic logic [PA-1:0] ref_paddr(input logic [VA-1:0] va);
    return {ref_ppn[va[PG +: mmu_pkg::TLB_ORDER]], va[PG-1:0]};
  endfunction

  task automatic send_cmd(input mmu_pkg::tlb_cmd_u cmd);
    @(posedge aclk);
    s_tlb_cmd_valid <= 1'b1;
    s_tlb_cmd       <= cmd;
    @(posedge aclk);
    s_tlb_cmd_valid <= 1'b0;
  endtask

  task automatic install(input logic [19:0] vpn, input logic [3:0] pid,
                         input logic [19:0] ppn);
    mmu_pkg::tlb_cmd_u cmd;
    cmd.install.op  = mmu_pkg::CMD_INSTALL;
    cmd.install.vpn = vpn;
    cmd.install.pid = pid;
    cmd.install.ppn = ppn;
    send_cmd(cmd);
    ref_vld[vpn[3:0]] = 1'b1;
    ref_tag[vpn[3:0]] = vpn[19:4];
    ref_pid[vpn[3:0]] = pid;
    ref_ppn[vpn[3:0]] = ppn;
  endtask

  // Clears only on matching tag and pid
  task automatic invalidate(input logic [19:0] vpn, input logic [3:0] pid);
    mmu_pkg::tlb_cmd_u cmd;
    cmd.invldt.op  = mmu_pkg::CMD_INVLDT;
    cmd.invldt.vpn = vpn;
    cmd.invldt.pid = pid;
    cmd.invldt.pad = '0;
    send_cmd(cmd);
    if (ref_tag[vpn[3:0]] == vpn[19:4] && ref_pid[vpn[3:0]] == pid) begin
      ref_vld[vpn[3:0]] = 1'b0;
    end
  endtask

  task automatic pulse_done(input bit is_wr);
    @(posedge aclk);
    if (is_wr) wr_xfer_done <= 1'b1;
    else rd_xfer_done <= 1'b1;
    @(posedge aclk);
    if (is_wr) wr_xfer_done <= 1'b0;
    else rd_xfer_done <= 1'b0;
  endtask

  task automatic pulse_resume(input bit is_wr);
    @(posedge aclk);
    if (is_wr) wr_pfault_resume <= 1'b1;
    else rd_pfault_resume <= 1'b1;
    @(posedge aclk);
    if (is_wr) wr_pfault_resume <= 1'b0;
    else rd_pfault_resume <= 1'b0;
  endtask

  task automatic send_req(input bit is_wr, input logic [VA-1:0] va,
                          input logic [15:0] len, input logic [3:0] pid);
    do @(negedge aclk); while (!(is_wr ? s_wr_req_ready : s_rd_req_ready));
    @(posedge aclk);
    if (is_wr) begin
      s_wr_req_valid <= 1'b1;
      s_wr_req_vaddr <= va;
      s_wr_req_len   <= len;
      s_wr_req_pid   <= pid;
    end else begin
      s_rd_req_valid <= 1'b1;
      s_rd_req_vaddr <= va;
      s_rd_req_len   <= len;
      s_rd_req_pid   <= pid;
    end
    @(posedge aclk);
    if (is_wr) s_wr_req_valid <= 1'b0;
    else s_rd_req_valid <= 1'b0;
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_dma(input bit is_wr,
                           input logic [PA-1:0] exp_pa, input logic [PA-1:0] got_pa,
                           input logic [mmu_pkg::LEN_BITS-1:0] exp_len,
                           input logic [mmu_pkg::LEN_BITS-1:0] got_len,
                           input logic [mmu_pkg::PID_BITS-1:0] exp_pid,
                           input logic [mmu_pkg::PID_BITS-1:0] got_pid);
    if (exp_pa !== got_pa || exp_len !== got_len || exp_pid !== got_pid) begin
      stop_run($sformatf("Fail at %0t: %s DMA %h/%h/%h, expected %h/%h/%h", $time,
                         is_wr ? "wr" : "rd", got_pa, got_len, got_pid,
                         exp_pa, exp_len, exp_pid));
    end
  endtask

  task automatic check_pfault(input bit is_wr,
                              input logic [VA-1:0] exp_va, input logic [VA-1:0] got_va,
                              input logic [mmu_pkg::PID_BITS-1:0] exp_pid,
                              input logic [mmu_pkg::PID_BITS-1:0] got_pid);
    if (exp_va !== got_va || exp_pid !== got_pid) begin
      stop_run($sformatf("Fail at %0t: %s page fault %h/%h, expected %h/%h", $time,
                         is_wr ? "wr" : "rd", got_va, got_pid, exp_va, exp_pid));
    end
  endtask

  // Samples at the falling edge until DMA or fault shows
  task automatic wait_outcome(input bit is_wr, output bit got_dma,
                              output logic [PA-1:0] pa, output logic [15:0] len,
                              output logic [3:0] pid);
    bit seen;
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge aclk);
      n++;
      if (is_wr ? m_wr_dma_valid : m_rd_dma_valid) begin
        seen = 1'b1;
        got_dma = 1'b1;
        pa  = is_wr ? m_wr_dma_paddr : m_rd_dma_paddr;
        len = is_wr ? m_wr_dma_len : m_rd_dma_len;
        pid = is_wr ? m_wr_dma_pid : m_rd_dma_pid;
      end else if (is_wr ? m_wr_pfault_valid : m_rd_pfault_valid) begin
        seen = 1'b1;
        got_dma = 1'b0;
        pa  = is_wr ? m_wr_pfault_vaddr : m_rd_pfault_vaddr;
        pid = is_wr ? m_wr_pfault_pid : m_rd_pfault_pid;
      end
    end
    if (!seen) stop_run("A request got neither a DMA request nor a page fault");
  endtask

  // One request, fault served with fix_ppn
  task automatic transact(input bit is_wr, input logic [VA-1:0] va,
                          input logic [15:0] len, input logic [3:0] pid,
                          input logic [19:0] fix_ppn, input bit give_back);
    bit              exp_hit;
    bit              got_dma;
    logic [PA-1:0]   pa;
    logic [15:0]     glen;
    logic [3:0]      gpid;
    exp_hit = ref_hit(va, pid);
    send_req(is_wr, va, len, pid);
    wait_outcome(is_wr, got_dma, pa, glen, gpid);
    if (!exp_hit) begin
      if (got_dma) stop_run($sformatf("Fail at %0t: DMA where a fault was due", $time));
      check_pfault(is_wr, va, pa, pid, gpid);
      install(va[VA-1:PG], pid, fix_ppn);
      pulse_resume(is_wr);
      wait_outcome(is_wr, got_dma, pa, glen, gpid);
    end
    if (!got_dma) stop_run($sformatf("Fail at %0t: fault where a hit was due", $time));
    check_dma(is_wr, ref_paddr(va), pa, len, glen, pid, gpid);
    if (give_back) pulse_done(is_wr);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  // Hit on an installed page
  task automatic test_hit();
    install(20'h12345, 4'h1, 20'hABCDE);
    transact(1'b0, 32'h1234_5678, 16'h0100, 4'h1, 20'h0, 1'b1);
  endtask

  // Miss, install, resume
  task automatic test_fault_resume();
    transact(1'b0, 32'h2000_0010, 16'h0020, 4'h3, 20'h5_5555, 1'b1);
  endtask

  // Pid mismatch, then invalidates with wrong and right pid
  task automatic test_pid_invalidate();
    transact(1'b1, 32'h1234_5000, 16'h0008, 4'h6, 20'h0_1111, 1'b1);
    invalidate(20'h12345, 4'h9);
    transact(1'b0, 32'h1234_5FFC, 16'h0004, 4'h6, 20'h0_2222, 1'b1);
    invalidate(20'h12345, 4'h6);
    transact(1'b0, 32'h1234_5004, 16'h0004, 4'h6, 20'h0_3333, 1'b1);
  endtask

  task automatic test_credit_stall();
    bit            got_dma;
    logic [PA-1:0] pa;
    logic [15:0]   len;
    logic [3:0]    pid;
    install(20'h00042, 4'h2, 20'h7_7000);
    for (int i = 0; i < mmu_pkg::N_CREDITS; i++) begin
      transact(1'b1, {20'h00042, 12'(i * 16)}, 16'(i + 1), 4'h2, 20'h0, 1'b0);
    end
    send_req(1'b1, 32'h0004_2ABC, 16'h0055, 4'h2);
    repeat (12) begin
      @(negedge aclk);
      if (m_wr_dma_valid || s_wr_req_ready) stop_run("Write issued or went ready with no credit");
    end
    pulse_done(1'b1);
    wait_outcome(1'b1, got_dma, pa, len, pid);
    if (!got_dma) stop_run("Stalled write ended in a page fault");
    check_dma(1'b1, ref_paddr(32'h0004_2ABC), pa, 16'h0055, len, 4'h2, pid);
    repeat (mmu_pkg::N_CREDITS) pulse_done(1'b1);
  endtask

  // Both channels in the same cycle
  task automatic test_both_channels();
    install(20'h00A01, 4'h5, 20'h1_0A01);
    install(20'h00B02, 4'h7, 20'h2_0B02);
    fork
      transact(1'b0, 32'h00A0_1123, 16'h0011, 4'h5, 20'h0, 1'b1);
      transact(1'b1, 32'h00B0_2456, 16'h0022, 4'h7, 20'h0, 1'b1);
    join
  endtask

  task automatic test_random();
    logic [19:0] vpn;
    logic [3:0]  pid;
    for (int i = 0; i < 20; i++) begin
      vpn = {15'h0, 1'(rand_bits(1)), 4'(rand_bits(4))};
      pid = 4'(4'd3 + rand_bits(1));
      if (rand_bits(1) != 0) install(vpn, pid, 20'(rand_bits(20)));
      transact(1'(rand_bits(1)), {vpn, 12'(rand_bits(12))}, 16'(rand_bits(16)), pid,
               20'(rand_bits(20)), 1'b1);
    end
  endtask

  initial begin
    aresetn = 1'b0;
    s_tlb_cmd_valid = 1'b0;
    s_tlb_cmd = '0;
    {s_rd_req_valid, s_wr_req_valid, rd_xfer_done, wr_xfer_done} = '0;
    {rd_pfault_resume, wr_pfault_resume} = '0;
    {s_rd_req_vaddr, s_wr_req_vaddr, s_rd_req_len, s_wr_req_len} = '0;
    {s_rd_req_pid, s_wr_req_pid} = '0;
    for (int i = 0; i < mmu_pkg::TLB_DEPTH; i++) ref_vld[i] = 1'b0;
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    if (!s_rd_req_ready || !s_wr_req_ready || m_rd_dma_valid || m_wr_dma_valid ||
        m_rd_pfault_valid || m_wr_pfault_valid) begin
      stop_run("Outputs are not in their reset state");
    end
    test_hit();
    test_fault_resume();
    test_pid_invalidate();
    test_credit_stall();
    test_both_channels();
    test_random();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- compile.f
source/mmu_pkg.sv
source/tlb_lookup_if.sv
source/tlb_store.sv
source/tlb_mutex.sv
source/translate_fsm.sv
source/dma_credit_gate.sv
source/mmu_region.sv
dv/mmu_region_properties.sv
dv/mmu_region_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -f compile.f \
  --top-module mmu_region_tb -o sim_mmu_region && ./obj_dir/sim_mmu_region 2>&1)
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1
